//--- common/emem_settings.svh
`ifndef EMEM_SETTINGS_SVH
`define EMEM_SETTINGS_SVH

// Fabric address and data width
`define EMEM_AW 32

// Full emesh packet width
`define EMEM_PW 104

// Rows of 64 bits in the array
// Row address width is clog2 of this
`define EMEM_DEPTH 65536

`endif

//--- common/emesh_pkg.sv
`default_nettype none

`include "emem_settings.svh"

package emesh_pkg;

   // Transfer size of a request
   typedef enum logic [1:0]
   {
      BYTE   = 2'b00,
      SHORT  = 2'b01,
      WORD   = 2'b10,
      DOUBLE = 2'b11
   } datamode_e;

   //####################
   // Packet views
   //####################

   // Write view, top field is the upper half of a double
   typedef struct packed
   {
      logic [`EMEM_AW-1:0] data_hi;
      logic [`EMEM_AW-1:0] data;
      logic [`EMEM_AW-1:0] dstaddr;
      logic [4:0]          ctrlmode;
      datamode_e           datamode;
      logic                write;
   } emesh_wr_view_s;

   // Read view, top field is where the response goes
   typedef struct packed
   {
      logic [`EMEM_AW-1:0] return_addr;
      logic [`EMEM_AW-1:0] data;
      logic [`EMEM_AW-1:0] dstaddr;
      logic [4:0]          ctrlmode;
      datamode_e           datamode;
      logic                write;
   } emesh_rd_view_s;

   // Same 104 bits, decoded by the write bit
   typedef union packed
   {
      emesh_wr_view_s wr;
      emesh_rd_view_s rd;
   } emesh_packet_u;

endpackage

`default_nettype wire

//--- common/emem_pkg.sv
`default_nettype none

`include "emem_settings.svh"

package emem_pkg;

   // Row index width
   localparam int MEM_AW = $clog2(`EMEM_DEPTH);

   // Byte address bits below the row index
   localparam int ROW_LSB = 3;

   //####################
   // Array types
   //####################

   // One 64-bit row
   typedef logic [63:0] mem_word_t;

   // Bit i enables byte i of a row
   typedef logic [7:0] byte_mask_t;

   // Row address
   typedef logic [MEM_AW-1:0] mem_addr_t;

endpackage

`default_nettype wire

//--- verilog/emem_req_decode.sv
`default_nettype none

`include "emem_settings.svh"

module emem_req_decode
   import emesh_pkg::*;
   import emem_pkg::*;
(
   input  wire logic                access_in,
   input  wire logic                ready,
   input  wire emesh_packet_u       packet_in,
   output logic                     mem_en,
   output logic                     mem_we,
   output mem_addr_t                mem_addr,
   output mem_word_t                mem_wdata,
   output byte_mask_t               mem_wmask,
   output logic                     rd_strobe,
   output datamode_e                rd_datamode,
   output logic [4:0]               rd_ctrlmode,
   output logic [2:0]               rd_lane,
   output logic [`EMEM_AW-1:0]      rd_return_addr
);

   logic       req_write;
   datamode_e  req_mode;
   logic [2:0] req_lane;
   byte_mask_t lane_mask;

   assign req_write = packet_in.wr.write;
   assign req_mode  = packet_in.wr.datamode;
   assign req_lane  = packet_in.wr.dstaddr[2:0];

   //####################
   // Request qualify
   //####################

   assign mem_en    = access_in & ready;   // Accepted this cycle
   assign mem_we    = mem_en & req_write;
   assign rd_strobe = mem_en & ~req_write;

   // 64-bit rows, byte address drops three bits
   assign mem_addr = packet_in.wr.dstaddr[ROW_LSB +: MEM_AW];

   //####################
   // Write data and mask
   //####################

   // Replicate small data across the row
   always_comb
   begin
      case (req_mode)
         BYTE:    mem_wdata = {8{packet_in.wr.data[7:0]}};
         SHORT:   mem_wdata = {4{packet_in.wr.data[15:0]}};
         WORD:    mem_wdata = {2{packet_in.wr.data}};
         default: mem_wdata = {packet_in.wr.data_hi, packet_in.wr.data};
      endcase
   end

   // Lanes touched by the access
   always_comb
   begin
      case (req_mode)
         BYTE:    lane_mask = byte_mask_t'(8'h01 << req_lane);
         SHORT:   lane_mask = byte_mask_t'(8'h03 << {req_lane[2:1], 1'b0});
         WORD:    lane_mask = byte_mask_t'(8'h0f << {req_lane[2], 2'b00});
         default: lane_mask = 8'hff;
      endcase
   end

   assign mem_wmask = lane_mask & {8{mem_we}};   // Nothing written on reads

   //####################
   // Read context
   //####################

   assign rd_datamode    = req_mode;
   assign rd_ctrlmode    = packet_in.rd.ctrlmode;
   assign rd_lane        = req_lane;
   assign rd_return_addr = packet_in.rd.return_addr;   // Response destination

   // Control fields of an accepted packet must be known
   always_comb
   begin
      if (mem_en)
      begin
         assert (!$isunknown({req_write, req_mode, packet_in.wr.dstaddr}))
         else $error("emem_req_decode: accepted packet has unknown control bits");
      end
   end

endmodule

`default_nettype wire

//--- verilog/emem_array.sv
`default_nettype none

`include "emem_settings.svh"

module emem_array
   import emem_pkg::*;
#(
   parameter int DEPTH = `EMEM_DEPTH
)
(
   input  wire logic       clk,
   input  wire logic       en,
   input  wire logic       we,
   input  wire mem_addr_t  addr,
   input  wire mem_word_t  wdata,
   input  wire byte_mask_t wmask,
   output mem_word_t       rdata
);

   localparam int ROW_W = $clog2(DEPTH);

   logic [ROW_W-1:0] row;
   mem_word_t        mem [0:DEPTH-1];

   // Smaller arrays use the low row bits
   assign row = addr[ROW_W-1:0];

   //####################
   // Storage
   //####################

   always_ff @(posedge clk)
   begin
      if (en && we)
      begin
         for (int i = 0; i < 8; i++)
         begin
            if (wmask[i])
               mem[row][i*8 +: 8] <= wdata[i*8 +: 8];   // Byte lane i
         end
      end
   end

   // Read data appears the cycle after the access
   always_ff @(posedge clk)
   begin
      if (en && !we)
         rdata <= mem[row];
   end

   // A mask on a non-write cycle would point at a decode fault
   a_mask_only_on_write : assert property (
      @(posedge clk) !we |-> (wmask == '0)
   ) else $error("emem_array: byte mask set without write");

endmodule

`default_nettype wire

//--- verilog/emem_rd_return.sv
`default_nettype none

`include "emem_settings.svh"

module emem_rd_return
   import emesh_pkg::*;
   import emem_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                nreset,
   input  wire logic                rd_strobe,
   input  wire datamode_e           rd_datamode,
   input  wire logic [4:0]          rd_ctrlmode,
   input  wire logic [2:0]          rd_lane,
   input  wire logic [`EMEM_AW-1:0] rd_return_addr,
   input  wire mem_word_t           rdata,
   output logic                     access_out,
   output emesh_packet_u            packet_out
);

   datamode_e           ret_mode;
   logic [4:0]          ret_ctrl;
   logic [2:0]          ret_lane;
   logic [`EMEM_AW-1:0] ret_addr;
   logic [`EMEM_AW-1:0] lo_word;
   logic [`EMEM_AW-1:0] hi_word;

   //####################
   // Read context
   //####################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else
         access_out <= rd_strobe;   // One cycle behind the array access
   end

   // Held alongside the array read
   always_ff @(posedge clk)
   begin
      if (rd_strobe)
      begin
         ret_mode <= rd_datamode;
         ret_ctrl <= rd_ctrlmode;
         ret_lane <= rd_lane;
         ret_addr <= rd_return_addr;
      end
   end

   //####################
   // Lane alignment
   //####################

   always_comb
   begin
      hi_word = '0;
      case (ret_mode)
         BYTE:    lo_word = {24'd0, rdata[{ret_lane, 3'b000} +: 8]};
         SHORT:   lo_word = {16'd0, rdata[{ret_lane[2:1], 4'b0000} +: 16]};
         WORD:    lo_word = rdata[{ret_lane[2], 5'b00000} +: 32];
         default:
         begin
            lo_word = rdata[31:0];
            hi_word = rdata[63:32];   // Upper half rides in the top field
         end
      endcase
   end

   // Response is a write back to the requester
   always_comb
   begin
      packet_out.wr = '{
         data_hi:  hi_word,
         data:     lo_word,
         dstaddr:  ret_addr,
         ctrlmode: ret_ctrl,
         datamode: ret_mode,
         write:    1'b1
      };
   end

   // A response carries the full context of its read
   a_resp_context_known : assert property (
      @(posedge clk) disable iff (!nreset)
         access_out |-> !$isunknown({ret_mode, ret_ctrl, ret_lane, ret_addr})
   ) else $error("emem_rd_return: response with unknown read context");

endmodule

`default_nettype wire

//--- verilog/ememory.sv
`default_nettype none

`include "emem_settings.svh"

module ememory
   import emesh_pkg::*;
   import emem_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          nreset,
   input  wire logic          access_in,
   input  wire emesh_packet_u packet_in,
   output logic               ready_out,
   output logic               access_out,
   output emesh_packet_u      packet_out,
   input  wire logic          ready_in
);

   logic                mem_en;
   logic                mem_we;
   mem_addr_t           mem_addr;
   mem_word_t           mem_wdata;
   byte_mask_t          mem_wmask;
   mem_word_t           mem_rdata;
   logic                rd_strobe;
   datamode_e           rd_datamode;
   logic [4:0]          rd_ctrlmode;
   logic [2:0]          rd_lane;
   logic [`EMEM_AW-1:0] rd_return_addr;

   // Fabric back-pressure only
   assign ready_out = ready_in;

   // Packet type must match the fabric width
   if ($bits(emesh_packet_u) != `EMEM_PW)
   begin : g_pw_check
      $error("ememory: packet type width differs from EMEM_PW");
   end

   //####################
   // Blocks
   //####################

   emem_req_decode u_decode (
      .access_in      (access_in),
      .ready          (ready_out),
      .packet_in      (packet_in),
      .mem_en         (mem_en),
      .mem_we         (mem_we),
      .mem_addr       (mem_addr),
      .mem_wdata      (mem_wdata),
      .mem_wmask      (mem_wmask),
      .rd_strobe      (rd_strobe),
      .rd_datamode    (rd_datamode),
      .rd_ctrlmode    (rd_ctrlmode),
      .rd_lane        (rd_lane),
      .rd_return_addr (rd_return_addr)
   );

   emem_array #(
      .DEPTH (`EMEM_DEPTH)
   ) u_array (
      .clk   (clk),
      .en    (mem_en),
      .we    (mem_we),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .wmask (mem_wmask),
      .rdata (mem_rdata)
   );

   emem_rd_return u_return (
      .clk            (clk),
      .nreset         (nreset),
      .rd_strobe      (rd_strobe),
      .rd_datamode    (rd_datamode),
      .rd_ctrlmode    (rd_ctrlmode),
      .rd_lane        (rd_lane),
      .rd_return_addr (rd_return_addr),
      .rdata          (mem_rdata),
      .access_out     (access_out),
      .packet_out     (packet_out)
   );

endmodule

`default_nettype wire

//--- verification/ememory_tb_tasks.svh
`ifndef EMEMORY_TB_TASKS_SVH
`define EMEMORY_TB_TASKS_SVH

//####################
// Failure and compare
//####################

task automatic abort_run();
   $display("Finished with errors");
   $fatal(1, "Simulation stopped at the first failure");
endtask

task automatic check_packet(input string name, input emesh_packet_u got,
                            input emesh_packet_u exp);
   if (got !== exp)
   begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
   end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp)
   begin
      $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
   end
endtask

//####################
// Packets and reference
//####################

function automatic emesh_packet_u make_write(input logic [31:0] addr, input datamode_e mode,
                                             input logic [31:0] lo, input logic [31:0] hi);
   emesh_packet_u p;
   p             = '0;
   p.wr.data_hi  = hi;
   p.wr.data     = lo;
   p.wr.dstaddr  = addr;
   p.wr.datamode = mode;
   p.wr.write    = 1'b1;
   return p;
endfunction

function automatic emesh_packet_u make_read(input logic [31:0] addr, input datamode_e mode,
                                            input logic [31:0] ret, input logic [4:0] ctrl);
   emesh_packet_u p;
   p                = '0;
   p.rd.return_addr = ret;
   p.rd.dstaddr     = addr;
   p.rd.ctrlmode    = ctrl;
   p.rd.datamode    = mode;
   p.rd.write       = 1'b0;
   return p;
endfunction

// Size-aligned bytes of the access land in their own lanes
task automatic ref_store(input logic [31:0] addr, input datamode_e mode,
                         input logic [31:0] lo, input logic [31:0] hi);
   int          size;
   int          first;
   mem_addr_t   row;
   logic [63:0] src;
   mem_word_t   word;
   size  = 1 << int'(mode);
   first = int'(addr[2:0]) & ~(size - 1);
   row   = mem_addr_t'(addr >> 3);
   src   = {hi, lo};
   word  = ref_mem.exists(row) ? ref_mem[row] : '0;
   for (int k = 0; k < size; k++)
      word[(first + k) * 8 +: 8] = src[k * 8 +: 8];
   ref_mem[row] = word;
endtask

function automatic emesh_packet_u expect_read(input logic [31:0] addr, input datamode_e mode,
                                              input logic [31:0] ret, input logic [4:0] ctrl);
   emesh_packet_u p;
   int            size;
   int            first;
   mem_word_t     word;
   logic [63:0]   val;
   size  = 1 << int'(mode);
   first = int'(addr[2:0]) & ~(size - 1);
   word  = ref_mem[mem_addr_t'(addr >> 3)];
   val   = '0;   // Unused upper bytes stay zero
   for (int k = 0; k < size; k++)
      val[k * 8 +: 8] = word[(first + k) * 8 +: 8];
   p             = '0;
   p.wr.data_hi  = val[63:32];
   p.wr.data     = val[31:0];
   p.wr.dstaddr  = ret;
   p.wr.ctrlmode = ctrl;
   p.wr.datamode = mode;
   p.wr.write    = 1'b1;
   return p;
endfunction

//####################
// Driving and waiting
//####################

// Returns at the falling edge after the accepting edge
task automatic send_packet(input emesh_packet_u p);
   @(negedge clk);
   access_in = 1'b1;
   packet_in = p;
   @(negedge clk);
   access_in = 1'b0;
endtask

task automatic wait_response(output emesh_packet_u p, output int waited);
   waited = 0;
   while (access_out !== 1'b1)
   begin
      if (waited == TIMEOUT)
      begin
         $display("No response packet within %0d cycles at time %0t", TIMEOUT, $time);
         abort_run();
      end
      @(negedge clk);
      waited++;
   end
   p = packet_out;
endtask

task automatic store_data(input logic [31:0] addr, input datamode_e mode,
                          input logic [31:0] lo, input logic [31:0] hi);
   send_packet(make_write(addr, mode, lo, hi));
   ref_store(addr, mode, lo, hi);
endtask

task automatic read_and_check(input logic [31:0] addr, input datamode_e mode,
                              input logic [31:0] ret, input logic [4:0] ctrl);
   emesh_packet_u got;
   int            waited;
   send_packet(make_read(addr, mode, ret, ctrl));
   wait_response(got, waited);
   check_packet("packet_out", got, expect_read(addr, mode, ret, ctrl));
   if (waited != 0)
   begin
      $display("Response came %0d cycles late at time %0t", waited, $time);
      abort_run();
   end
   @(negedge clk);
   check_bit("access_out", access_out, 1'b0);   // One cycle only
endtask

//####################
// Directed tests
//####################

task automatic test_idle_and_ready();
   check_bit("access_out", access_out, 1'b0);
   @(negedge clk);
   ready_in  = 1'b0;
   access_in = 1'b1;
   packet_in = make_read(32'h0000_0100, DOUBLE, 32'h8000_0000, 5'h01);
   @(posedge clk);
   check_bit("ready_out", ready_out, 1'b0);
   @(negedge clk);
   access_in = 1'b0;
   for (int i = 0; i < 3; i++)
   begin
      check_bit("access_out", access_out, 1'b0);   // Offer was ignored
      @(negedge clk);
   end
   ready_in = 1'b1;
   @(posedge clk);
   check_bit("ready_out", ready_out, 1'b1);
endtask

task automatic test_double_rw();
   store_data(32'h0000_0100, DOUBLE, 32'h89ab_cdef, 32'h0123_4567);
   read_and_check(32'h0000_0100, DOUBLE, 32'h8000_0040, 5'h15);
endtask

task automatic test_byte_lanes();
   for (int i = 0; i < 8; i++)
      store_data(32'h0000_0200 + i, BYTE, {24'hdeadbe, 8'(8'h11 * (i + 1))}, 32'hffff_ffff);
   read_and_check(32'h0000_0200, DOUBLE, 32'h8000_0080, 5'h0a);
endtask

task automatic test_lane_reads();
   store_data(32'h0000_0300, DOUBLE, 32'hb4a5_9687, 32'hf0e1_d2c3);
   for (int i = 0; i < 4; i++)
      read_and_check(32'h0000_0300 + 2 * i, SHORT, 32'h8000_1000 + i, 5'h02);
   read_and_check(32'h0000_0303, SHORT, 32'h8000_1100, 5'h03);   // Odd address aligns down
   for (int i = 0; i < 2; i++)
      read_and_check(32'h0000_0300 + 4 * i, WORD, 32'h8000_2000 + i, 5'h04);
   for (int i = 0; i < 8; i++)
      read_and_check(32'h0000_0300 + i, BYTE, 32'h8000_3000 + i, 5'h05);
endtask

task automatic test_write_blocked();
   store_data(32'h0000_0400, DOUBLE, 32'h5555_aaaa, 32'h3333_cccc);
   @(negedge clk);
   ready_in  = 1'b0;
   access_in = 1'b1;
   packet_in = make_write(32'h0000_0400, DOUBLE, 32'h0bad_0bad, 32'h0bad_0bad);
   @(negedge clk);
   access_in = 1'b0;
   ready_in  = 1'b1;
   read_and_check(32'h0000_0400, DOUBLE, 32'h8000_4000, 5'h06);   // Row unchanged
endtask

// Pops the response due this cycle, if any
task automatic collect_response(ref emesh_packet_u expq[$]);
   check_bit("access_out", access_out, expq.size() != 0);
   if (access_out === 1'b1)
      check_packet("packet_out", packet_out, expq.pop_front());
endtask

task automatic test_random_stream();
   emesh_packet_u expq[$];
   logic [31:0]   rnd;
   logic [31:0]   addr;
   logic [31:0]   lo;
   logic [31:0]   hi;
   logic [31:0]   ret;
   datamode_e     mode;
   for (int r = 0; r < 8; r++)
      store_data(32'h0000_1000 + 8 * r, DOUBLE, $random(seed), $random(seed));
   for (int n = 0; n < 60; n++)
   begin
      @(negedge clk);
      collect_response(expq);
      rnd  = $random(seed);
      lo   = $random(seed);
      hi   = $random(seed);
      ret  = $random(seed);
      mode = datamode_e'(rnd[1:0]);
      addr = 32'h0000_1000 + {26'd0, rnd[8:3]};   // Eight rows of the window
      access_in = 1'b1;
      if (rnd[2])
      begin
         packet_in = make_write(addr, mode, lo, hi);
         ref_store(addr, mode, lo, hi);
      end
      else
      begin
         packet_in = make_read(addr, mode, ret, rnd[13:9]);
         expq.push_back(expect_read(addr, mode, ret, rnd[13:9]));
      end
   end
   @(negedge clk);
   access_in = 1'b0;
   collect_response(expq);
   @(negedge clk);
   collect_response(expq);   // Nothing left in flight
endtask

`endif

//--- verification/ememory_tb.sv
`default_nettype none

`include "emem_settings.svh"

module ememory_tb
   import emesh_pkg::*;
   import emem_pkg::*;
();

   localparam int TIMEOUT = 20;   // Cycles allowed for one response

   logic          clk;
   logic          nreset;
   logic          access_in;
   emesh_packet_u packet_in;
   logic          ready_out;
   logic          access_out;
   emesh_packet_u packet_out;
   logic          ready_in;

   integer        seed;

   // Reference rows, filled as the tests write
   mem_word_t     ref_mem [mem_addr_t];

   //####################
   // Clock and DUT
   //####################

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ememory u_ememory (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .ready_out  (ready_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .ready_in   (ready_in)
   );

   `include "ememory_tb_tasks.svh"

   //####################
   // Test sequence
   //####################

   initial
   begin
      seed      = 32'h8d5cff44;
      nreset    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      ready_in  = 1'b1;

      repeat (8) @(negedge clk);   // Reset held for 8 cycles
      nreset = 1'b1;

      test_idle_and_ready();
      test_double_rw();
      test_byte_lanes();
      test_lane_reads();
      test_write_blocked();
      test_random_stream();

      repeat (2) @(negedge clk);
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- ememory.f
+incdir+common
+incdir+verification
common/emesh_pkg.sv
common/emem_pkg.sv
verilog/emem_req_decode.sv
verilog/emem_array.sv
verilog/emem_rd_return.sv
verilog/ememory.sv
verification/ememory_tb.sv

//--- Makefile
# Verilator build and run of the ememory testbench

TOP = ememory_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f ememory.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
